// File: busResponder.sv
/* reply merger: picks the valid source and registers the host ack */
`timescale 1ns/1ps

module busResponder (
    input  logic               CLK,
    input  logic               rstN,
    input  nextorPkg::srcRspT  directRsp,
    input  nextorPkg::srcRspT  ramRsp,
    input  nextorPkg::srcRspT  spiRsp,
    output nextorPkg::busRspT  busRsp
);
    import nextorPkg::*;

    logic    anyValid;
    busDataT selData;
    logic    ackQ;
    busDataT dataQ;

    // only one source is valid in any cycle
    always_comb begin
        anyValid = directRsp.valid || ramRsp.valid || spiRsp.valid;
        if (ramRsp.valid) begin
            selData = ramRsp.data;
        end else if (spiRsp.valid) begin
            selData = spiRsp.data;
        end else if (directRsp.valid) begin
            selData = directRsp.data;
        end else begin
            // open bus floats high
            selData = 8'hff;
        end
    end

    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            ackQ  <= 1'b0;
            dataQ <= 8'hff;
        end else begin
            ackQ  <= anyValid;
            dataQ <= selData;
        end
    end

    assign busRsp = '{ack: ackQ, rdData: dataQ};

endmodule

// File: megaromMapper.sv
/* 8 KB two-bank megaROM mapper: bank registers, write protect and
   routing of each host cycle to RAM, the TF SPI port or a direct reply */
`timescale 1ns/1ps

module megaromMapper #(
    parameter nextorPkg::ramAddrT ramBase = '0
) (
    input  logic               CLK,
    input  logic               rstN,
    input  nextorPkg::busReqT  busReq,
    output nextorPkg::ramReqT  ramRead,
    output nextorPkg::spiReqT  spiReq,
    output nextorPkg::srcRspT  directRsp
);
    import nextorPkg::*;

    // captured host request, fields stay valid until the reply
    busReqT      reqQ;
    logic        stbQ;

    bankT        bank0;
    bankT        bank1;

    // decode of the captured request
    logic [12:0] offset;
    logic        tfMapped;
    spiRegT      spiSel;
    logic        spiHit;
    logic        ramHit;
    logic        bank0Wr;
    logic        bank1Wr;
    logic        direct;

    // second stage for the direct reply, lines it up with the SPI reply
    logic        directQ;

    // stage 1: latch the strobe and its payload
    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            stbQ <= 1'b0;
        end else begin
            stbQ <= busReq.stb;
        end
    end

    always_ff @(posedge CLK) begin
        if (busReq.stb) begin
            reqQ <= busReq;
        end
    end

    always_comb begin
        offset = reqQ.addr[12:0];
        // TF port replaces the lower window while bank 0 holds 40h
        tfMapped = (bank0 == tfBankSel) && (reqQ.addr[15:13] == 3'b010);

        // 1C00h-1DFFh data port, 1E00h control, 1E01h status
        if (offset[12:9] == 4'he) begin
            spiSel = spiData;
        end else if (offset == 13'h1e00) begin
            spiSel = spiCtrl;
        end else if (offset == 13'h1e01) begin
            spiSel = spiStatus;
        end else begin
            spiSel = spiNone;
        end

        spiHit = stbQ && reqQ.slotSel && tfMapped && (spiSel != spiNone);

        // ROM reads in 4000h-7FFFh, 8000h-BFFFh is disabled
        ramHit = stbQ && reqQ.slotSel && !reqQ.write && !tfMapped
            && (reqQ.addr[15:14] == 2'b01);

        bank0Wr = stbQ && reqQ.slotSel && reqQ.write
            && ((reqQ.addr & bankRegMask) == bank0RegAddr);
        bank1Wr = stbQ && reqQ.slotSel && reqQ.write
            && ((reqQ.addr & bankRegMask) == bank1RegAddr);

        // everything else answers here: bank writes, protected writes,
        // unmapped reads and cycles for another slot
        direct = stbQ && !spiHit && !ramHit;
    end

    // bank registers
    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            bank0 <= '0;
            bank1 <= '0;
        end else begin
            if (bank0Wr) begin
                bank0 <= reqQ.wrData;
            end
            if (bank1Wr) begin
                bank1 <= reqQ.wrData;
            end
        end
    end

    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            directQ <= 1'b0;
        end else begin
            directQ <= direct;
        end
    end

    // RAM byte = base + bank * 2000h + offset
    assign ramRead = '{
        stb:  ramHit,
        addr: ramBase + ramAddrT'({(reqQ.addr[13] ? bank1 : bank0), offset})
    };

    assign spiReq = '{
        stb:    spiHit,
        write:  reqQ.write,
        regSel: spiSel,
        wrData: reqQ.wrData
    };

    // open bus level for every direct reply
    assign directRsp = '{valid: directQ, data: 8'hff};

endmodule

// File: nextorCartridge.sv
/* Nextor cartridge top: mapper, RAM port, TF SPI controller and responder */
`timescale 1ns/1ps

module nextorCartridge #(
    parameter nextorPkg::ramAddrT ramBase   = 21'h100000,
    parameter int                 spiClkDiv = 2
) (
    input  logic               CLK,
    input  logic               rstN,
    input  nextorPkg::busReqT  busReq,
    output nextorPkg::busRspT  busRsp,
    output nextorPkg::ramReqT  ramReq,
    input  nextorPkg::ramRspT  ramRsp,
    output logic               sdClk,
    output logic               sdMosi,
    input  logic               sdMiso,
    output logic               sdCsN,
    output logic               led
);
    import nextorPkg::*;

    // mapper outputs
    ramReqT ramRead;
    spiReqT spiReq;
    srcRspT directRsp;

    // replies into the responder
    srcRspT ramSrc;
    srcRspT spiSrc;

    megaromMapper #(
        .ramBase(ramBase)
    ) mapper0 (
        .CLK(CLK),
        .rstN(rstN),
        .busReq(busReq),
        .ramRead(ramRead),
        .spiReq(spiReq),
        .directRsp(directRsp)
    );

    ramPort ramPort0 (
        .CLK(CLK),
        .rstN(rstN),
        .readReq(ramRead),
        .ramReq(ramReq),
        .ramRsp(ramRsp),
        .rsp(ramSrc)
    );

    // TF card lives behind bank 0 = 40h
    tfSpiController #(
        .spiClkDiv(spiClkDiv)
    ) tfSpi0 (
        .CLK(CLK),
        .rstN(rstN),
        .spiReq(spiReq),
        .rsp(spiSrc),
        .sdClk(sdClk),
        .sdMosi(sdMosi),
        .sdMiso(sdMiso),
        .sdCsN(sdCsN),
        .led(led)
    );

    busResponder responder0 (
        .CLK(CLK),
        .rstN(rstN),
        .directRsp(directRsp),
        .ramRsp(ramSrc),
        .spiRsp(spiSrc),
        .busRsp(busRsp)
    );

endmodule

// File: nextorCartridgeTb.sv
/* testbench for the Nextor cartridge: clock, reset, RAM and SD card models,
   stim file reader, bus cycle driver, checks and timeout */
`timescale 1ns/1ps

module nextorCartridgeTb;
    import nextorPkg::*;

    // five hex words per stim line: op, slot, addr, data, expect
    localparam int stimDepth     = 512;
    localparam int wordsPerLine  = 5;
    localparam int cyclesPerLine = 64;

    logic   CLK;
    logic   rstN;
    busReqT busReq;
    busRspT busRsp;
    ramReqT ramReq;
    ramRspT ramRsp;
    logic   sdClk;
    logic   sdMosi;
    logic   sdMiso = 1'b1;
    logic   sdCsN;
    logic   led;

    logic [15:0] stim [0:stimDepth-1];
    integer      seed         = 32'hec60;
    int          cycleCnt     = 0;
    int          timeoutLimit = 0;

    // SD card side: last byte shifted in, bit position within the byte
    logic [7:0] sdRx   = 8'h00;
    logic [7:0] sdLast = 8'h00;
    logic [2:0] sdBit  = 3'd0;

    nextorCartridge #(
        .ramBase(21'h100000),
        .spiClkDiv(2)
    ) dut0 (
        .CLK(CLK),
        .rstN(rstN),
        .busReq(busReq),
        .busRsp(busRsp),
        .ramReq(ramReq),
        .ramRsp(ramRsp),
        .sdClk(sdClk),
        .sdMosi(sdMosi),
        .sdMiso(sdMiso),
        .sdCsN(sdCsN),
        .led(led)
    );

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    // RAM content: xor of the three address bytes
    function automatic busDataT ramByte(input ramAddrT a);
        return a[7:0] ^ a[15:8] ^ {3'b000, a[20:16]};
    endfunction

    task automatic abortRun();
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic checkByte(input string name, input busDataT got, input busDataT exp);
        assert (got == exp) else begin
            $display("Fail at %0d ns: %s got %h expected %h", $time, name, got, exp);
            abortRun();
        end
    endtask

    task automatic checkPin(input string name, input logic got, input logic exp);
        assert (got == exp) else begin
            $display("Fail at %0d ns: %s got %b expected %b", $time, name, got, exp);
            abortRun();
        end
    endtask

    // one host cycle, fields held until the registered ack
    task automatic busCycle(input logic wr, input logic slot, input busAddrT a,
                            input busDataT d, output busDataT rd);
        @(posedge CLK);
        #1;
        busReq = '{stb: 1'b1, write: wr, slotSel: slot, addr: a, wrData: d};
        @(posedge CLK);
        #1;
        busReq.stb = 1'b0;
        do begin
            @(posedge CLK);
        end while (!busRsp.ack);
        rd = busRsp.rdData;
    endtask

    // RAM with 1 to 4 cycles of latency
    initial begin : ramModel
        int      latency;
        ramAddrT addrQ;
        ramRsp = '0;
        forever begin
            @(posedge CLK);
            if (ramReq.stb) begin
                addrQ   = ramReq.addr;
                latency = 1 + ($random(seed) & 3);
                repeat (latency - 1) @(posedge CLK);
                #1 ramRsp = '{ack: 1'b1, rdData: ramByte(addrQ)};
                @(posedge CLK);
                #1 ramRsp = '0;
            end
        end
    end

    // SD card, MOSI in on rising sdClk
    // MISO sends back the complement of the previous byte, MSB first
    always @(posedge sdClk) begin
        sdRx = {sdRx[6:0], sdMosi};
        if (sdBit == 3'd7) begin
            sdLast = sdRx;
        end
        sdBit = sdBit + 3'd1;
        #1 sdMiso = ~sdLast[3'd7 - sdBit];
    end

    // run limit scales with the stim length
    always @(posedge CLK) begin
        cycleCnt <= cycleCnt + 1;
        if (timeoutLimit > 0 && cycleCnt >= timeoutLimit) begin
            $display("timeout: run did not finish within %0d cycles", timeoutLimit);
            abortRun();
        end
    end

    initial begin : main
        int      numLines;
        int      i;
        int      base;
        logic    slot;
        busAddrT a;
        busDataT d;
        busDataT exp;
        busDataT rd;
        busReq = '0;
        rstN   = 1'b0;
        for (i = 0; i < stimDepth; i++) begin
            stim[i] = 16'h0000;
        end
        $readmemh("nextorStim.txt", stim);
        // op 0 marks the end of the file
        numLines = 0;
        while ((numLines + 1) * wordsPerLine <= stimDepth
                && stim[numLines * wordsPerLine] != 16'h0000) begin
            numLines++;
        end
        timeoutLimit = (numLines + 1) * cyclesPerLine;

        repeat (3) @(posedge CLK);
        #1;
        rstN = 1'b1;
        checkPin("busRsp.ack", busRsp.ack, 1'b0);
        checkPin("ramReq.stb", ramReq.stb, 1'b0);

        for (i = 0; i < numLines; i++) begin
            base = i * wordsPerLine;
            slot = stim[base + 1][0];
            a    = stim[base + 2];
            d    = stim[base + 3][7:0];
            exp  = stim[base + 4][7:0];
            case (stim[base])
                16'd1: busCycle(1'b1, slot, a, d, rd);
                16'd2: begin
                    busCycle(1'b0, slot, a, 8'h00, rd);
                    checkByte($sformatf("busRsp.rdData at %h", a), rd, exp);
                end
                16'd3: begin
                    // status bit 0 stays set until the eighth falling edge
                    do begin
                        busCycle(1'b0, slot, a, 8'h00, rd);
                    end while (rd[0]);
                    checkByte($sformatf("busRsp.rdData at %h", a), rd, exp);
                end
                16'd4: begin
                    @(posedge CLK);
                    checkPin("led", led, exp[0]);
                    checkPin("sdCsN", sdCsN, exp[1]);
                end
                default: begin
                    $display("stim line %0d holds an unknown op %h", i, stim[base]);
                    abortRun();
                end
            endcase
        end

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// File: nextorPkg.sv
/* shared types for the Nextor cartridge: host bus, RAM port, SPI access
   and reply structs, plus the mapper address constants */
package nextorPkg;

    // widths with a meaning on the host side
    typedef logic [15:0] busAddrT;
    typedef logic [7:0]  busDataT;

    // byte address into shared RAM (2 MB)
    typedef logic [20:0] ramAddrT;

    // one 8 KB bank register
    typedef logic [7:0]  bankT;

    // SPI register select, decoded from the TF window offset
    typedef enum logic [1:0] {
        spiData   = 2'd0,
        spiCtrl   = 2'd1,
        spiStatus = 2'd2,
        spiNone   = 2'd3
    } spiRegT;

    // host request, fields held until ack
    typedef struct packed {
        logic    stb;
        logic    write;
        logic    slotSel;
        busAddrT addr;
        busDataT wrData;
    } busReqT;

    // cartridge reply, ack is one cycle
    typedef struct packed {
        logic    ack;
        busDataT rdData;
    } busRspT;

    // read request toward shared RAM
    typedef struct packed {
        logic    stb;
        ramAddrT addr;
    } ramReqT;

    // RAM reply after a variable latency
    typedef struct packed {
        logic    ack;
        busDataT rdData;
    } ramRspT;

    // mapper to SPI controller register access
    typedef struct packed {
        logic    stb;
        logic    write;
        spiRegT  regSel;
        busDataT wrData;
    } spiReqT;

    // one source's reply into the responder
    typedef struct packed {
        logic    valid;
        busDataT data;
    } srcRspT;

    // bank registers decode on the top five address bits
    localparam busAddrT bankRegMask  = 16'hf800;
    localparam busAddrT bank0RegAddr = 16'h6000;
    localparam busAddrT bank1RegAddr = 16'h6800;

    // bank 0 value that swaps the TF port into 4000h-5FFFh
    localparam bankT tfBankSel = 8'h40;

endpackage

// File: nextorStim.txt
// op: 1 write, 2 read and compare, 3 poll status until idle, 4 pins (bit0 led, bit1 sdCsN)
// op slot addr data expect
4 1 0000 00 02
2 1 4000 00 10
2 1 6000 00 10
2 1 4123 00 32
2 1 7fff 00 f0
1 1 6000 03 00
2 1 4000 00 70
2 1 5abc 00 d6
1 1 6800 05 00
2 1 6000 00 b0
2 1 7234 00 96
1 1 6f00 07 00
2 1 6010 00 e0
1 1 4000 aa 00
1 1 7000 12 00
2 1 4000 00 70
2 1 6010 00 e0
2 1 8000 00 ff
2 1 a123 00 ff
2 1 0000 00 ff
1 0 6000 09 00
2 0 4000 00 ff
2 1 4000 00 70
1 1 6000 40 00
2 1 4000 00 ff
2 1 6000 00 f0
2 1 5e00 00 00
2 1 5e01 00 00
1 1 5e00 01 00
4 1 0000 00 01
2 1 5e00 00 01
1 1 5c00 a5 00
2 1 5e01 00 01
3 1 5e01 00 00
2 1 5c00 00 ff
1 1 5d00 3c 00
3 1 5e01 00 00
2 1 5c00 00 5a
1 1 5c00 0f 00
1 1 5c00 77 00
3 1 5e01 00 00
2 1 5c00 00 c3
1 1 5c00 00 00
3 1 5e01 00 00
2 1 5dff 00 f0
1 1 5e00 00 00
4 1 0000 00 02
2 1 5e00 00 00
1 1 6000 03 00
2 1 4000 00 70
2 1 5abc 00 d6

// File: project.f
nextorPkg.sv
megaromMapper.sv
ramPort.sv
tfSpiController.sv
busResponder.sv
nextorCartridge.sv
nextorCartridgeTb.sv

// File: ramPort.sv
/* RAM read sequencer: one outstanding read over the variable-latency
   RAM handshake, returned as a one-cycle reply */
`timescale 1ns/1ps

module ramPort (
    input  logic               CLK,
    input  logic               rstN,
    input  nextorPkg::ramReqT  readReq,
    output nextorPkg::ramReqT  ramReq,
    input  nextorPkg::ramRspT  ramRsp,
    output nextorPkg::srcRspT  rsp
);
    import nextorPkg::*;

    typedef enum logic {
        idle,
        waitAck
    } stateT;

    stateT   state;
    logic    stbQ;
    ramAddrT addrQ;
    logic    validQ;
    busDataT dataQ;

    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            state  <= idle;
            stbQ   <= 1'b0;
            validQ <= 1'b0;
        end else begin
            // strobe and reply are single-cycle pulses
            stbQ   <= 1'b0;
            validQ <= 1'b0;
            case (state)
                idle: begin
                    if (readReq.stb) begin
                        stbQ  <= 1'b1;
                        state <= waitAck;
                    end
                end
                waitAck: begin
                    // RAM may take any number of cycles
                    if (ramRsp.ack) begin
                        validQ <= 1'b1;
                        state  <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // address and returned byte
    always_ff @(posedge CLK) begin
        if (state == idle && readReq.stb) begin
            addrQ <= readReq.addr;
        end
        if (state == waitAck && ramRsp.ack) begin
            dataQ <= ramRsp.rdData;
        end
    end

    assign ramReq = '{stb: stbQ, addr: addrQ};
    assign rsp    = '{valid: validQ, data: dataQ};

endmodule

// File: run.sh
#!/usr/bin/env bash
# build and run the Nextor cartridge testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f project.f --top-module nextorCartridgeTb \
    -o simNextor \
    && ./obj_dir/simNextor > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "TEST RESULT: PASS" sim.log && echo "simulation passed" && exit 0 \
    || { echo "simulation failed"; exit 1; }

// File: tfSpiController.sv
/* memory-mapped mode-0 SPI master for the TF card with chip-select
   control, a busy status bit and the activity LED */
`timescale 1ns/1ps

module tfSpiController #(
    parameter int spiClkDiv = 2
) (
    input  logic               CLK,
    input  logic               rstN,
    input  nextorPkg::spiReqT  spiReq,
    output nextorPkg::srcRspT  rsp,
    output logic               sdClk,
    output logic               sdMosi,
    input  logic               sdMiso,
    output logic               sdCsN,
    output logic               led
);
    import nextorPkg::*;

    localparam int divW = (spiClkDiv > 1) ? $clog2(spiClkDiv) : 1;

    typedef enum logic {
        idle,
        shift
    } stateT;

    stateT           state;
    logic [divW-1:0] divCnt;
    logic [2:0]      bitCnt;
    logic [7:0]      shiftQ;
    logic            misoQ;
    logic            sdClkQ;
    logic            csQ;
    busDataT         rxByte;
    logic            busy;
    logic            halfDone;
    logic            startXfer;

    // register reply
    logic            validQ;
    busDataT         dataQ;

    assign busy     = (state == shift);
    assign halfDone = (divCnt == divW'(spiClkDiv - 1));
    // data writes while busy are dropped, host polls status
    assign startXfer = spiReq.stb && spiReq.write && (spiReq.regSel == spiData) && !busy;

    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            state  <= idle;
            divCnt <= '0;
            bitCnt <= '0;
            shiftQ <= 8'hff;
            misoQ  <= 1'b0;
            sdClkQ <= 1'b0;
            rxByte <= 8'hff;
        end else begin
            case (state)
                idle: begin
                    if (startXfer) begin
                        // first bit on MOSI before the first rising edge
                        shiftQ <= spiReq.wrData;
                        divCnt <= '0;
                        bitCnt <= '0;
                        state  <= shift;
                    end
                end
                shift: begin
                    if (halfDone) begin
                        divCnt <= '0;
                        sdClkQ <= !sdClkQ;
                        if (!sdClkQ) begin
                            // rising edge, sample MISO
                            misoQ <= sdMiso;
                        end else begin
                            // falling edge, next bit out
                            shiftQ <= {shiftQ[6:0], misoQ};
                            bitCnt <= bitCnt + 3'd1;
                            if (bitCnt == 3'd7) begin
                                rxByte <= {shiftQ[6:0], misoQ};
                                state  <= idle;
                            end
                        end
                    end else begin
                        divCnt <= divCnt + divW'(1);
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // control register, bit 0 drives chip select
    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            csQ <= 1'b0;
        end else if (spiReq.stb && spiReq.write && spiReq.regSel == spiCtrl) begin
            csQ <= spiReq.wrData[0];
        end
    end

    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            validQ <= 1'b0;
        end else begin
            validQ <= spiReq.stb;
        end
    end

    always_ff @(posedge CLK) begin
        case (spiReq.regSel)
            spiData:   dataQ <= rxByte;
            spiCtrl:   dataQ <= {7'd0, csQ};
            spiStatus: dataQ <= {7'd0, busy};
            default:   dataQ <= 8'hff;
        endcase
    end

    assign rsp    = '{valid: validQ, data: dataQ};
    assign sdClk  = sdClkQ;
    assign sdMosi = shiftQ[7];
    assign sdCsN  = !csQ;
    // LED lit while the card is selected
    assign led    = csQ;

endmodule
